// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard source/*.sv) $(wildcard verif/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN) verif/cache_golden.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
source/cache_pkg.sv
source/cache_ifs.sv
source/cache_ctrl.sv
source/line_store.sv
source/burst_engine.sv
source/cache_top.sv
verif/cache_tb.sv

// ==== source/burst_engine.sv ====
`timescale 1ns/100ps

module burst_engine (
        input  logic        i_clk,
        input  logic        i_reset,
        line_xfer_if.engine xfer,
        output logic        o_wb_cyc,
        output logic        o_wb_stb,
        output logic [31:0] o_wb_adr,
        output logic [31:0] o_wb_dat,
        output logic [3:0]  o_wb_sel,
        output logic        o_wb_we,
        output logic [2:0]  o_wb_cti,
        input  logic        i_wb_ack,
        input  logic [31:0] i_wb_dat
);
        import cache_pkg::*;

        logic [1:0] beat;
        logic [1:0] beat_nxt;
        logic       start;
        logic       beat_ok;
        logic       last_beat;
        logic       done_q;
        line_t      line_buf;

        assign start     = !o_wb_cyc && xfer.req && !done_q;
        assign beat_ok   = o_wb_stb && i_wb_ack;
        // Classic cycles and the EOB beat both end the transfer
        assign last_beat = (o_wb_cti != CTI_BURST);
        assign beat_nxt  = beat + 2'd1;

        assign xfer.done  = done_q;
        assign xfer.rline = line_buf;
        assign xfer.rdat  = line_buf[0];

        // -------------------------------------------------------------------------
        // Cycle control
        // -------------------------------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                        o_wb_cti <= CTI_CLASSIC;
                        beat     <= '0;
                        done_q   <= 1'b0;
                end
                else
                begin
                        done_q <= 1'b0;
                        if (start)
                        begin
                                o_wb_cyc <= 1'b1;
                                o_wb_stb <= 1'b1;
                                o_wb_we  <= xfer.we;
                                o_wb_cti <= xfer.single ? CTI_CLASSIC : CTI_BURST;
                                beat     <= '0;
                        end
                        else if (beat_ok)
                        begin
                                if (last_beat)
                                begin
                                        o_wb_cyc <= 1'b0;
                                        o_wb_stb <= 1'b0;
                                        o_wb_we  <= 1'b0;
                                        o_wb_cti <= CTI_CLASSIC;
                                        done_q   <= 1'b1;
                                end
                                else
                                begin
                                        beat     <= beat_nxt;
                                        o_wb_cti <= (beat_nxt == 2'd3) ? CTI_EOB : CTI_BURST;
                                end
                        end
                end
        end

        // Address, data and select only move on an accepted beat
        always_ff @(posedge i_clk)
        begin
                if (start)
                begin
                        o_wb_adr <= xfer.single ?
                                {xfer.addr.bus.line, xfer.addr.bus.offset[3:2], 2'b00} :
                                {xfer.addr.bus.line, 4'b0000};
                        o_wb_dat <= xfer.single ? xfer.wdat : xfer.wline[0];
                        o_wb_sel <= (xfer.single && xfer.we) ? xfer.wsel : 4'b1111;
                end
                else if (beat_ok && !last_beat)
                begin
                        o_wb_adr <= {xfer.addr.bus.line, beat_nxt, 2'b00};
                        o_wb_dat <= xfer.wline[beat_nxt];
                end

                if (beat_ok && !o_wb_we)
                        line_buf[beat] <= i_wb_dat;
        end

        a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
                o_wb_stb |-> o_wb_cyc);

        a_adr_stall: assert property (@(posedge i_clk) disable iff (i_reset)
                (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr));

endmodule

// ==== source/cache_ctrl.sv ====
`timescale 1ns/100ps

module cache_ctrl (
        input  logic                   i_clk,
        input  logic                   i_reset,
        input  cache_pkg::cache_addr_u i_addr,
        input  logic                   i_rd,
        input  logic                   i_wr,
        input  logic [31:0]            i_din,
        input  logic [3:0]             i_ben,
        input  logic                   i_cache_en,
        output logic [31:0]            o_dat,
        output logic                   o_ack,
        store_if.ctrl                  store,
        line_xfer_if.ctrl              xfer
);
        import cache_pkg::*;

        ctrl_state_e      state;
        ctrl_state_e      state_nxt;
        logic [INDEX_W:0] clr_cnt;
        logic             clearing;
        logic             cacheable;
        logic             hit;
        logic             req;
        cache_addr_u      victim_addr;

        // Top bit of the counter marks the end of the valid clear
        assign clearing  = !clr_cnt[INDEX_W];
        assign cacheable = i_cache_en && !i_addr.cache.tag[TAG_W-1];
        assign hit       = store.valid_rd && (store.tag_rd == i_addr.cache.tag);
        assign req       = i_rd || i_wr;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state   <= IDLE;
                        clr_cnt <= '0;
                end
                else
                begin
                        state <= state_nxt;
                        if (clearing)
                                clr_cnt <= clr_cnt + 1'b1;
                end
        end

        // Victim line address rebuilt from the stored tag
        always_comb
        begin
                victim_addr                = i_addr;
                victim_addr.cache.tag      = store.tag_rd;
                victim_addr.cache.word     = '0;
                victim_addr.cache.byte_off = '0;
        end

        // -------------------------------------------------------------------------
        // Transfer request drops with done so the ack never overlaps it
        // -------------------------------------------------------------------------
        assign xfer.req    = (state inside {EVICT, FILL, UNCACHED}) && !xfer.done;
        assign xfer.we     = (state == EVICT) || ((state == UNCACHED) && i_wr);
        assign xfer.single = (state == UNCACHED);
        assign xfer.addr   = (state == EVICT) ? victim_addr : i_addr;
        assign xfer.wdat   = i_din;
        assign xfer.wsel   = i_ben;
        assign xfer.wline  = store.line_rd;

        assign store.index = clearing ? clr_cnt[INDEX_W-1:0] : i_addr.cache.index;
        assign o_dat = (state == UNCACHED) ? xfer.rdat : store.line_rd[i_addr.cache.word];

        always_comb
        begin
                state_nxt      = state;
                o_ack          = 1'b0;
                store.tag_we   = clearing;
                store.tag_wr   = i_addr.cache.tag;
                store.valid_wr = !clearing;
                store.dirty_wr = 1'b0;
                store.line_wr  = xfer.rline;
                store.ben      = '0;

                case (state)
                IDLE:
                begin
                        if (!clearing && req)
                        begin
                                if (!cacheable)
                                        state_nxt = UNCACHED;
                                else if (!hit)
                                        state_nxt = (store.valid_rd && store.dirty_rd) ? EVICT : FILL;
                                else if (i_rd)
                                        o_ack = 1'b1;
                                else
                                begin
                                        // Same word in all four slots and the enable picks one
                                        state_nxt      = WRITE_HIT;
                                        store.tag_we   = 1'b1;
                                        store.dirty_wr = 1'b1;
                                        store.line_wr  = {4{i_din}};
                                        store.ben      = LINE_BYTES'(i_ben) << {i_addr.cache.word, 2'b00};
                                end
                        end
                end

                UNCACHED:
                begin
                        if (xfer.done)
                        begin
                                o_ack     = 1'b1;
                                state_nxt = IDLE;
                        end
                end

                WRITE_HIT:
                begin
                        o_ack     = 1'b1;
                        state_nxt = IDLE;
                end

                EVICT:
                begin
                        if (xfer.done)
                                state_nxt = FILL;
                end

                FILL:
                begin
                        // Fetched line goes in clean
                        if (xfer.done)
                        begin
                                store.tag_we = 1'b1;
                                store.ben    = '1;
                                state_nxt    = REFRESH;
                        end
                end

                REFRESH:
                        state_nxt = IDLE;

                default:
                        state_nxt = IDLE;
                endcase
        end

        a_no_ack_in_xfer: assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_ack && xfer.req));

endmodule

// ==== source/cache_ifs.sv ====
`timescale 1ns/100ps

// Controller to tag and line store
interface store_if;
        import cache_pkg::*;

        logic [INDEX_W-1:0]    index;
        logic                  tag_we;
        logic [TAG_W-1:0]      tag_wr;
        logic                  valid_wr;
        logic                  dirty_wr;
        line_t                 line_wr;
        logic [LINE_BYTES-1:0] ben;

        // Read side with no latency
        logic [TAG_W-1:0]      tag_rd;
        logic                  valid_rd;
        logic                  dirty_rd;
        line_t                 line_rd;

        modport ctrl  (output index, tag_we, tag_wr, valid_wr, dirty_wr, line_wr, ben,
                       input  tag_rd, valid_rd, dirty_rd, line_rd);
        modport store (input  index, tag_we, tag_wr, valid_wr, dirty_wr, line_wr, ben,
                       output tag_rd, valid_rd, dirty_rd, line_rd);
endinterface

// Controller to Wishbone burst engine
interface line_xfer_if;
        import cache_pkg::*;

        logic        req;
        logic        we;
        logic        single;
        cache_addr_u addr;
        logic [31:0] wdat;
        logic [3:0]  wsel;
        line_t       wline;

        logic        done;
        line_t       rline;
        logic [31:0] rdat;

        modport ctrl   (output req, we, single, addr, wdat, wsel, wline,
                        input  done, rline, rdat);
        modport engine (input  req, we, single, addr, wdat, wsel, wline,
                        output done, rline, rdat);
endinterface

// ==== source/cache_pkg.sv ====
package cache_pkg;

        // -------------------------------------------------------------------------
        // Cache geometry
        // -------------------------------------------------------------------------
        localparam int LINE_BYTES = 16;
        localparam int NUM_LINES  = 64;
        localparam int INDEX_W    = 6;
        localparam int TAG_W      = 22;

        // Wishbone cycle type indicator
        localparam logic [2:0] CTI_CLASSIC = 3'b000;
        localparam logic [2:0] CTI_BURST   = 3'b010;
        localparam logic [2:0] CTI_EOB     = 3'b111;

        // One address word as seen by the cache or by the bus
        typedef union packed {
                struct packed {
                        logic [TAG_W-1:0]   tag;
                        logic [INDEX_W-1:0] index;
                        logic [1:0]         word;
                        logic [1:0]         byte_off;
                } cache;
                struct packed {
                        logic [31-$clog2(LINE_BYTES):0]  line;
                        logic [$clog2(LINE_BYTES)-1:0]   offset;
                } bus;
        } cache_addr_u;

        // Word 0 sits in the low 32 bits
        typedef logic [LINE_BYTES/4-1:0][31:0] line_t;

        typedef enum logic [2:0] {
                IDLE,
                UNCACHED,
                WRITE_HIT,
                EVICT,
                FILL,
                REFRESH
        } ctrl_state_e;

endpackage

// ==== source/cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
        input  logic                                       i_clk,
        input  logic                                       i_reset,

        // Processor side
        input  logic [$bits(cache_pkg::cache_addr_u)-1:0]  i_addr,
        input  logic                                       i_rd,
        input  logic                                       i_wr,
        input  logic [31:0]                                i_din,
        input  logic [3:0]                                 i_ben,
        input  logic                                       i_cache_en,
        output logic [31:0]                                o_dat,
        output logic                                       o_ack,

        // Wishbone master
        output logic                                       o_wb_cyc,
        output logic                                       o_wb_stb,
        output logic [$bits(cache_pkg::cache_addr_u)-1:0]  o_wb_adr,
        output logic [31:0]                                o_wb_dat,
        output logic [3:0]                                 o_wb_sel,
        output logic                                       o_wb_we,
        output logic [$bits(cache_pkg::CTI_CLASSIC)-1:0]   o_wb_cti,
        input  logic                                       i_wb_ack,
        input  logic [31:0]                                i_wb_dat
);

        store_if     st_if ();
        line_xfer_if xf_if ();

        cache_ctrl u_ctrl (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_addr     (i_addr),
                .i_rd       (i_rd),
                .i_wr       (i_wr),
                .i_din      (i_din),
                .i_ben      (i_ben),
                .i_cache_en (i_cache_en),
                .o_dat      (o_dat),
                .o_ack      (o_ack),
                .store      (st_if),
                .xfer       (xf_if)
        );

        line_store u_store (
                .i_clk (i_clk),
                .st    (st_if)
        );

        burst_engine u_burst (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .xfer     (xf_if),
                .o_wb_cyc (o_wb_cyc),
                .o_wb_stb (o_wb_stb),
                .o_wb_adr (o_wb_adr),
                .o_wb_dat (o_wb_dat),
                .o_wb_sel (o_wb_sel),
                .o_wb_we  (o_wb_we),
                .o_wb_cti (o_wb_cti),
                .i_wb_ack (i_wb_ack),
                .i_wb_dat (i_wb_dat)
        );

endmodule

// ==== source/line_store.sv ====
`timescale 1ns/100ps

module line_store (
        input  logic  i_clk,
        store_if.store st
);
        import cache_pkg::*;

        logic [LINE_BYTES-1:0][7:0] data_mem [NUM_LINES];
        logic [TAG_W-1:0]           tag_mem  [NUM_LINES];
        logic [NUM_LINES-1:0]       valid_mem;
        logic [NUM_LINES-1:0]       dirty_mem;
        logic [LINE_BYTES-1:0][7:0] wr_bytes;

        // Byte view of the incoming line
        assign wr_bytes = st.line_wr;

        assign st.line_rd  = data_mem[st.index];
        assign st.tag_rd   = tag_mem[st.index];
        assign st.valid_rd = valid_mem[st.index];
        assign st.dirty_rd = dirty_mem[st.index];

        // -------------------------------------------------------------------------
        // Data array merged per byte
        // -------------------------------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                for (int b = 0; b < LINE_BYTES; b++)
                begin
                        if (st.ben[b])
                                data_mem[st.index][b] <= wr_bytes[b];
                end
        end

        // Tag, valid and dirty move together
        always_ff @(posedge i_clk)
        begin
                if (st.tag_we)
                begin
                        tag_mem[st.index]   <= st.tag_wr;
                        valid_mem[st.index] <= st.valid_wr;
                        dirty_mem[st.index] <= st.dirty_wr;
                end
        end

        a_tag_index_known: assert property (@(posedge i_clk)
                st.tag_we |-> !$isunknown(st.index));

endmodule

// ==== verif/cache_golden.txt ====
# op en addr wdata ben expected_rdata burst_reads burst_writes classic_cycles
# memory word at byte address A starts as 7fffffff - A, bit 31 of addr means uncached
R 1 00000040 00000000 0 7fffffbf 1 0 0
R 1 00000040 00000000 0 7fffffbf 0 0 0
R 1 0000004c 00000000 0 7fffffb3 0 0 0
W 1 00000044 a5a5a5a5 3 00000000 0 0 0
R 1 00000044 00000000 0 7fffa5a5 0 0 0
W 1 00000048 12345678 c 00000000 0 0 0
R 1 00000440 00000000 0 7ffffbbf 1 1 0
R 1 80000044 00000000 0 7fffa5a5 0 0 1
R 1 80000048 00000000 0 1234ffb7 0 0 1
W 1 80000100 deadbeef f 00000000 0 0 1
R 1 80000100 00000000 0 deadbeef 0 0 1
W 1 80000104 00c0ffee 4 00000000 0 0 1
R 1 80000104 00000000 0 7fc0fefb 0 0 1
R 0 00000100 00000000 0 deadbeef 0 0 1
W 0 00000200 11223344 1 00000000 0 0 1
R 1 00000200 00000000 0 7ffffd44 1 0 0
R 1 00000440 00000000 0 7ffffbbf 0 0 0
R 1 00000040 00000000 0 7fffffbf 1 0 0
R 1 00000044 00000000 0 7fffa5a5 0 0 0
W 1 0000004c cafef00d f 00000000 0 0 0
W 1 0000004c 00000077 1 00000000 0 0 0
R 1 0000004c 00000000 0 cafef077 0 0 0
R 1 00000840 00000000 0 7ffff7bf 1 1 0
R 1 8000004c 00000000 0 cafef077 0 0 1
R 1 80000040 00000000 0 7fffffbf 0 0 1
W 1 00000300 0000ab00 2 00000000 1 0 0
R 1 80000300 00000000 0 7ffffcff 0 0 1
R 1 00000300 00000000 0 7fffabff 0 0 0

// ==== verif/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;
        import cache_pkg::*;

        localparam int          ACK_LIMIT   = 400;
        localparam int          CLEAR_LIMIT = 200;
        localparam int          MEM_WORDS   = 1024;
        localparam logic [31:0] SEED        = 32'h02d7_fcee;

        logic        i_clk;
        logic        i_reset;
        logic [31:0] i_addr;
        logic        i_rd;
        logic        i_wr;
        logic [31:0] i_din;
        logic [3:0]  i_ben;
        logic        i_cache_en;
        logic [31:0] o_dat;
        logic        o_ack;
        logic        o_wb_cyc;
        logic        o_wb_stb;
        logic [31:0] o_wb_adr;
        logic [31:0] o_wb_dat;
        logic [3:0]  o_wb_sel;
        logic        o_wb_we;
        logic [2:0]  o_wb_cti;
        logic        i_wb_ack = 1'b0;
        logic [31:0] i_wb_dat = '0;

        // Memory model state and bus cycle counters
        logic [31:0] mem [MEM_WORDS];
        int          ack_wait   = 0;
        int          burst_beat = 0;
        logic [31:0] burst_base = '0;
        int          n_burst_rd = 0;
        int          n_burst_wr = 0;
        int          n_classic  = 0;

        // Access in flight
        logic [31:0] cur_addr;
        logic        cur_wr;
        logic [3:0]  cur_ben;

        cache_top uut (.*);

        initial
        begin
                i_clk = 1'b0;
                forever
                        #2 i_clk = ~i_clk;
        end

        initial
        begin
                for (int i = 0; i < MEM_WORDS; i++)
                        mem[i] = ~(32'(i) << 2) & 32'h7fff_ffff;
        end

        // -------------------------------------------------------------------------
        // Compare and failure tasks
        // -------------------------------------------------------------------------
        task automatic stop_run(input string msg);
                $display("%s", msg);
                $display("TESTS FAILED");
                $fatal(1, "simulation stopped at the first failure");
        endtask

        task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
                if (got !== exp)
                        stop_run($sformatf("error at %0t: %s is %h, expected %h",
                                           $time, what, got, exp));
        endtask

        task automatic check_count(input int got, input int exp, input string what);
                if (got != exp)
                        stop_run($sformatf("error at %0t: %0d %s, expected %0d",
                                           $time, got, what, exp));
        endtask

        task automatic compare_code(input logic [3:0] got, input logic [3:0] exp,
                                    input string what);
                if (got !== exp)
                        stop_run($sformatf("error at %0t: %s is %b, expected %b",
                                           $time, what, got, exp));
        endtask

        // -------------------------------------------------------------------------
        // Wishbone memory model with an ack after 0 to 3 idle cycles
        // -------------------------------------------------------------------------
        always @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        i_wb_ack <= 1'b0;
                        ack_wait   = 0;
                        burst_beat = 0;
                end
                else if (i_wb_ack)
                begin
                        // Beat taken at this edge
                        i_wb_ack <= 1'b0;
                        ack_wait = $urandom_range(3, 0);
                end
                else if (o_wb_stb && ack_wait > 0)
                        ack_wait = ack_wait - 1;
                else if (o_wb_stb)
                begin
                        $display("beat adr %h cti %b we %b sel %b",
                                 o_wb_adr, o_wb_cti, o_wb_we, o_wb_sel);
                        if (o_wb_cti == CTI_CLASSIC)
                        begin
                                compare_code(o_wb_sel, cur_wr ? cur_ben : 4'hf, "classic select");
                                check_word(o_wb_adr, {cur_addr[31:2], 2'b00}, "classic address");
                                n_classic++;
                        end
                        else
                        begin
                                if (burst_beat == 0)
                                begin
                                        // Victim and fill share the index of the access
                                        burst_base = o_wb_adr;
                                        check_word(o_wb_adr & 32'h3ff, cur_addr & 32'h3f0,
                                                   "burst line address");
                                        if (!o_wb_we)
                                                check_word(o_wb_adr, cur_addr & 32'hffff_fff0,
                                                           "fill line address");
                                end
                                check_word(o_wb_adr, burst_base + 32'(4 * burst_beat),
                                           "burst beat address");
                                compare_code(4'(o_wb_cti),
                                             4'((burst_beat == 3) ? CTI_EOB : CTI_BURST),
                                             "burst cycle type");
                                compare_code(o_wb_sel, 4'hf, "burst select");
                                if (burst_beat == 3)
                                begin
                                        burst_beat = 0;
                                        if (o_wb_we)
                                                n_burst_wr++;
                                        else
                                                n_burst_rd++;
                                end
                                else
                                        burst_beat++;
                        end

                        if (o_wb_we)
                        begin
                                for (int b = 0; b < 4; b++)
                                begin
                                        if (o_wb_sel[b])
                                                mem[o_wb_adr[11:2]][b*8 +: 8] = o_wb_dat[b*8 +: 8];
                                end
                        end
                        else
                                i_wb_dat <= mem[o_wb_adr[11:2]];
                        i_wb_ack <= 1'b1;
                end
        end

        // -------------------------------------------------------------------------
        // Processor side
        // -------------------------------------------------------------------------
        task automatic wait_clear();
                int cycles;
                cycles = 0;
                while (uut.u_ctrl.clearing)
                begin
                        @(negedge i_clk);
                        if (o_ack || o_wb_cyc || o_wb_stb)
                                stop_run($sformatf("error at %0t: ack or bus active before %s",
                                                   $time, "the first request"));
                        cycles++;
                        if (cycles > CLEAR_LIMIT)
                                stop_run("timeout while the valid bits were being cleared");
                end
        endtask

        task automatic run_access(input logic [7:0] op, input logic en,
                                  input logic [31:0] addr, input logic [31:0] wdat,
                                  input logic [3:0] ben, input logic [31:0] exp,
                                  input int exp_br, input int exp_bw, input int exp_cl);
                int cycles;
                int br0;
                int bw0;
                int cl0;
                br0    = n_burst_rd;
                bw0    = n_burst_wr;
                cl0    = n_classic;
                cycles = 0;
                @(posedge i_clk);
                cur_addr = addr;
                cur_wr   = (op == "W");
                cur_ben  = ben;
                i_addr     <= addr;
                i_rd       <= (op == "R");
                i_wr       <= (op == "W");
                i_din      <= wdat;
                i_ben      <= ben;
                i_cache_en <= en;
                @(negedge i_clk);
                while (!o_ack)
                begin
                        cycles++;
                        if (cycles > ACK_LIMIT)
                                stop_run($sformatf("timeout waiting for ack on %c access to %h",
                                                   op, addr));
                        @(negedge i_clk);
                end
                if (op == "R")
                        check_word(o_dat, exp, $sformatf("read data at %h", addr));
                check_count(n_burst_rd - br0, exp_br, "burst reads");
                check_count(n_burst_wr - bw0, exp_bw, "burst writes");
                check_count(n_classic - cl0, exp_cl, "classic cycles");
                @(posedge i_clk);
                i_rd <= 1'b0;
                i_wr <= 1'b0;
        endtask

        task automatic play_golden();
                int          fd;
                int          code;
                int          lineno;
                int          ops;
                string       line;
                logic [7:0]  op;
                logic        en;
                logic [31:0] addr;
                logic [31:0] wdat;
                logic [3:0]  ben;
                logic [31:0] exp;
                int          e_br;
                int          e_bw;
                int          e_cl;
                lineno = 0;
                ops    = 0;
                fd = $fopen("verif/cache_golden.txt", "r");
                if (fd == 0)
                        stop_run("cannot open the golden file verif/cache_golden.txt");
                while (!$feof(fd))
                begin
                        code = $fgets(line, fd);
                        lineno++;
                        if (code == 0 || line.len() < 2 || line[0] == "#")
                                continue;
                        code = $sscanf(line, "%c %h %h %h %h %h %d %d %d", op, en, addr,
                                       wdat, ben, exp, e_br, e_bw, e_cl);
                        if (code != 9)
                                stop_run($sformatf("golden file line %0d is malformed", lineno));
                        run_access(op, en, addr, wdat, ben, exp, e_br, e_bw, e_cl);
                        ops++;
                end
                $fclose(fd);
                if (ops == 0)
                        stop_run("the golden file holds no operations");
        endtask

        initial
        begin
                void'($urandom(SEED));
                i_reset    <= 1'b1;
                i_addr     <= '0;
                i_rd       <= 1'b0;
                i_wr       <= 1'b0;
                i_din      <= '0;
                i_ben      <= '0;
                i_cache_en <= 1'b0;
                cur_addr = '0;
                cur_wr   = 1'b0;
                cur_ben  = '0;
                repeat (8)
                        @(posedge i_clk);
                i_reset <= 1'b0;
                wait_clear();
                play_golden();
                $display("TESTS PASSED");
                $finish;
        end

endmodule
